// File: source/syn_weight_pkg.sv
/*
 * syn_weight_pkg
 * shared widths and types of the banked synaptic weight store,
 * including the entry held in the recall queue
 */

`default_nettype none

package syn_weight_pkg;

	// stored weight and scaled synaptic word
	localparam int WEIGHT_W   = 12;
	localparam int SYN_DATA_W = 16;

	// bank decode, top address bits pick the bank
	localparam int BANK_SEL_W = 2;
	localparam int NUM_BANKS  = 4;

	typedef logic [WEIGHT_W-1:0]   weight_t;
	typedef logic [SYN_DATA_W-1:0] syn_data_t;
	typedef logic [BANK_SEL_W-1:0] bank_sel_t;

	// axon scaling code, 0..3 selects shift 0, 1, 2 or 4
	typedef logic [1:0] scale_code_t;

	// scaled weight travels with the code that produced it
	typedef struct packed {
		syn_data_t   data;
		scale_code_t code;
	} recall_entry_t;

endpackage : syn_weight_pkg

`default_nettype wire

// File: source/weight_recall_port.sv
/*
 * weight_recall_port
 * accepts recall requests, decodes the bank from the top address bits
 * and keeps the bank select and in-flight flag for the next cycle
 */

`timescale 1ns/1ps
`default_nettype none

module weight_recall_port import syn_weight_pkg::*;
#(
	parameter int BANK_ADDR_W = 8
)
(
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	input  wire logic                          start_i,
	input  wire logic [BANK_SEL_W+BANK_ADDR_W-1:0] recall_addr_i,
	input  wire logic                          recall_en_i,
	input  wire logic                          recall_ready_i,
	output logic      [NUM_BANKS-1:0]          bank_rd_en_o,
	output logic      [BANK_ADDR_W-1:0]        bank_rd_addr_o,
	output bank_sel_t                          bank_sel_o,
	output logic                               push_o
);

	bank_sel_t rd_bank;
	logic      accept;

	assign accept         = recall_en_i & recall_ready_i;
	assign rd_bank        = recall_addr_i[BANK_SEL_W+BANK_ADDR_W-1:BANK_ADDR_W];
	assign bank_rd_addr_o = recall_addr_i[BANK_ADDR_W-1:0];

	// one-hot read enable, only for an accepted request
	always_comb
	begin
		bank_rd_en_o = '0;
		bank_rd_en_o[rd_bank] = accept;
	end

	// select follows the accepted request so the output mux lines up
	// with the registered read address in the banks
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			bank_sel_o <= '0;
			push_o     <= 1'b0;
		end
		else
		begin
			if (accept)
				bank_sel_o <= rd_bank;
			// start drops the entry that would land next edge
			push_o <= accept & ~start_i;
		end
	end

endmodule : weight_recall_port

`default_nettype wire

// File: source/weight_bank_array.sv
/*
 * weight_bank_array
 * four weight banks with registered read address and a write port each,
 * the registered bank select picks the weight returned to the queue
 */

`timescale 1ns/1ps
`default_nettype none

module weight_bank_array import syn_weight_pkg::*;
#(
	parameter int BANK_ADDR_W = 8
)
(
	input  wire logic             clk_i,
	input  wire logic [NUM_BANKS-1:0]   bank_rd_en_i,
	input  wire logic [BANK_ADDR_W-1:0] bank_rd_addr_i,
	input  bank_sel_t             bank_sel_i,
	input  wire logic [NUM_BANKS-1:0]   bank_wr_en_i,
	input  wire logic [BANK_ADDR_W-1:0] bank_wr_addr_i,
	input  weight_t               bank_wr_data_i,
	output weight_t               rd_weight_o
);

	localparam int BANK_DEPTH = 2 ** BANK_ADDR_W;

	weight_t bank_rd_data [NUM_BANKS];

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		weight_t                mem [BANK_DEPTH];
		logic [BANK_ADDR_W-1:0] rd_addr_q;

		// read address only moves when this bank is addressed,
		// so the last recalled word stays on the output
		always_ff @(posedge clk_i)
		begin
			if (bank_rd_en_i[b])
				rd_addr_q <= bank_rd_addr_i;
			if (bank_wr_en_i[b])
				mem[bank_wr_addr_i] <= bank_wr_data_i;
		end

		// asynchronous read after the address register,
		// a write at the request edge is already visible
		assign bank_rd_data[b] = mem[rd_addr_q];
	end

	assign rd_weight_o = bank_rd_data[bank_sel_i];

endmodule : weight_bank_array

`default_nettype wire

// File: source/learn_writeback.sv
/*
 * learn_writeback
 * holds the scale code of the last popped entry, scales the learned
 * weight back to 12 bits and decodes the bank write
 */

`timescale 1ns/1ps
`default_nettype none

module learn_writeback import syn_weight_pkg::*;
#(
	parameter int BANK_ADDR_W = 8
)
(
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	input  scale_code_t                        popped_scale_i,
	input  wire logic                          pop_i,
	input  wire logic [BANK_SEL_W+BANK_ADDR_W-1:0] wr_addr_i,
	input  syn_data_t                          wr_data_i,
	input  wire logic                          wr_en_i,
	input  wire logic                          wr_config_i,
	output logic      [NUM_BANKS-1:0]          bank_wr_en_o,
	output logic      [BANK_ADDR_W-1:0]        bank_wr_addr_o,
	output weight_t                            bank_wr_data_o
);

	scale_code_t held_scale;
	weight_t     scaled_back;
	bank_sel_t   wr_bank;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			held_scale <= '0;
		else if (pop_i)
			held_scale <= popped_scale_i;
	end

	// undo the recall shift
	always_comb
	begin
		case (held_scale)
			2'd1:    scaled_back = wr_data_i[12:1];
			2'd2:    scaled_back = wr_data_i[13:2];
			2'd3:    scaled_back = wr_data_i[15:4];
			default: scaled_back = wr_data_i[11:0];
		endcase
	end

	// config writes bypass the scaling
	assign bank_wr_data_o = wr_config_i ? wr_data_i[WEIGHT_W-1:0] : scaled_back;

	assign wr_bank        = wr_addr_i[BANK_SEL_W+BANK_ADDR_W-1:BANK_ADDR_W];
	assign bank_wr_addr_o = wr_addr_i[BANK_ADDR_W-1:0];

	always_comb
	begin
		bank_wr_en_o = '0;
		bank_wr_en_o[wr_bank] = wr_en_i;
	end

endmodule : learn_writeback

`default_nettype wire

// File: source/recall_queue.sv
/*
 * recall_queue
 * scales the recalled weight by the axon code and queues it with its code
 * for the learning side, with ready/valid derived from the occupancy
 */

`timescale 1ns/1ps
`default_nettype none

module recall_queue import syn_weight_pkg::*;
#(
	parameter int FIFO_AW = 4
)
(
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire logic  start_i,
	input  weight_t    rd_weight_i,
	input  scale_code_t recall_scale_i,
	input  wire logic  recall_en_i,
	input  wire logic  push_i,
	output logic       recall_ready_o,
	input  wire logic  learn_rd_en_i,
	output logic       learn_valid_o,
	output syn_data_t  learn_data_o,
	output scale_code_t popped_scale_o,
	output logic       pop_o
);

	localparam int unsigned DEPTH = 2 ** FIFO_AW;

	recall_entry_t      fifo_mem [DEPTH];
	recall_entry_t      push_entry;
	recall_entry_t      head_entry;
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   occupancy;
	logic [FIFO_AW:0]   occ_pending;
	scale_code_t        scale_q;
	logic               sign;
	logic               push;
	logic               pop;

	// code rides one cycle behind the request to meet its weight
	always_ff @(posedge clk_i)
	begin
		if (recall_en_i && recall_ready_o)
			scale_q <= recall_scale_i;
	end

	assign sign = rd_weight_i[WEIGHT_W-1];

	always_comb
	begin
		push_entry.code = scale_q;
		case (scale_q)
			2'd1:    push_entry.data = {{3{sign}}, rd_weight_i, 1'b0};
			2'd2:    push_entry.data = {{2{sign}}, rd_weight_i, 2'b00};
			// shift by 4 fills the word, no room for sign bits
			2'd3:    push_entry.data = {rd_weight_i, 4'b0000};
			default: push_entry.data = {{4{sign}}, rd_weight_i};
		endcase
	end

	// in-flight entry counts against the free space
	assign occ_pending    = occupancy + {{FIFO_AW{1'b0}}, push_i};
	assign recall_ready_o = (occ_pending <= (FIFO_AW+1)'(DEPTH - 1));
	assign learn_valid_o  = (occupancy != '0);

	assign push = push_i & ~start_i;
	assign pop  = learn_rd_en_i & learn_valid_o;

	always_ff @(posedge clk_i)
	begin
		if (push)
			fifo_mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end
		else if (start_i)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				occupancy <= occupancy + 1'b1;
			else if (pop && !push)
				occupancy <= occupancy - 1'b1;
		end
	end

	assign head_entry     = fifo_mem[rd_ptr];
	assign learn_data_o   = head_entry.data;
	assign popped_scale_o = head_entry.code;
	assign pop_o          = pop;

endmodule : recall_queue

`default_nettype wire

// File: source/syn_weight_store.sv
/*
 * syn_weight_store
 * banked synaptic weight store, recall reads feed a scaled queue
 * for the learning side, learning writes are scaled back into the banks
 */

`timescale 1ns/1ps
`default_nettype none

module syn_weight_store import syn_weight_pkg::*;
#(
	parameter int BANK_ADDR_W = 8,
	parameter int FIFO_AW     = 4
)
(
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	input  wire logic                          start_i,
	input  wire logic [BANK_SEL_W+BANK_ADDR_W-1:0] recall_addr_i,
	input  scale_code_t                        recall_scale_i,
	input  wire logic                          recall_en_i,
	output logic                               recall_ready_o,
	input  wire logic                          learn_rd_en_i,
	output logic                               learn_valid_o,
	output syn_data_t                          learn_data_o,
	input  wire logic [BANK_SEL_W+BANK_ADDR_W-1:0] wr_addr_i,
	input  syn_data_t                          wr_data_i,
	input  wire logic                          wr_en_i,
	input  wire logic                          wr_config_i
);

	logic [NUM_BANKS-1:0]   bank_rd_en;
	logic [BANK_ADDR_W-1:0] bank_rd_addr;
	bank_sel_t              bank_sel;
	logic                   push;
	weight_t                rd_weight;
	scale_code_t            popped_scale;
	logic                   pop;
	logic [NUM_BANKS-1:0]   bank_wr_en;
	logic [BANK_ADDR_W-1:0] bank_wr_addr;
	weight_t                bank_wr_data;

	weight_recall_port #(.BANK_ADDR_W(BANK_ADDR_W)) u_recall_port (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.start_i        (start_i),
		.recall_addr_i  (recall_addr_i),
		.recall_en_i    (recall_en_i),
		.recall_ready_i (recall_ready_o),
		.bank_rd_en_o   (bank_rd_en),
		.bank_rd_addr_o (bank_rd_addr),
		.bank_sel_o     (bank_sel),
		.push_o         (push)
	);

	weight_bank_array #(.BANK_ADDR_W(BANK_ADDR_W)) u_bank_array (
		.clk_i          (clk_i),
		.bank_rd_en_i   (bank_rd_en),
		.bank_rd_addr_i (bank_rd_addr),
		.bank_sel_i     (bank_sel),
		.bank_wr_en_i   (bank_wr_en),
		.bank_wr_addr_i (bank_wr_addr),
		.bank_wr_data_i (bank_wr_data),
		.rd_weight_o    (rd_weight)
	);

	recall_queue #(.FIFO_AW(FIFO_AW)) u_recall_queue (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.start_i        (start_i),
		.rd_weight_i    (rd_weight),
		.recall_scale_i (recall_scale_i),
		.recall_en_i    (recall_en_i),
		.push_i         (push),
		.recall_ready_o (recall_ready_o),
		.learn_rd_en_i  (learn_rd_en_i),
		.learn_valid_o  (learn_valid_o),
		.learn_data_o   (learn_data_o),
		.popped_scale_o (popped_scale),
		.pop_o          (pop)
	);

	learn_writeback #(.BANK_ADDR_W(BANK_ADDR_W)) u_writeback (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.popped_scale_i (popped_scale),
		.pop_i          (pop),
		.wr_addr_i      (wr_addr_i),
		.wr_data_i      (wr_data_i),
		.wr_en_i        (wr_en_i),
		.wr_config_i    (wr_config_i),
		.bank_wr_en_o   (bank_wr_en),
		.bank_wr_addr_o (bank_wr_addr),
		.bank_wr_data_o (bank_wr_data)
	);

endmodule : syn_weight_store

`default_nettype wire

// File: verification/syn_weight_store_checker.sv
/*
 * syn_weight_store_checker
 * occupancy and flag rules of the recall queue, bound into recall_queue
 */

`timescale 1ns/1ps
`default_nettype none

module syn_weight_store_checker
#(
	parameter int FIFO_AW = 4
)
(
	input wire logic               clk_i,
	input wire logic               rst_n_i,
	input wire logic [FIFO_AW:0]   occupancy_i,
	input wire logic [FIFO_AW-1:0] wr_ptr_i,
	input wire logic [FIFO_AW-1:0] rd_ptr_i,
	input wire logic               push_i,
	input wire logic               learn_valid_i
);

	localparam logic [FIFO_AW:0] DEPTH = (FIFO_AW+1)'(2 ** FIFO_AW);

	int fail_count;

	assert property (@(posedge clk_i) disable iff (!rst_n_i) occupancy_i <= DEPTH)
	else
	begin
		$error("recall queue occupancy above its depth");
		fail_count++;
	end

	// pointers together and not full means empty, so no data on offer
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(wr_ptr_i == rd_ptr_i) && (occupancy_i != DEPTH) |-> !learn_valid_i)
	else
	begin
		$error("learn valid high with an empty recall queue");
		fail_count++;
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> occupancy_i < DEPTH)
	else
	begin
		$error("push into a full recall queue");
		fail_count++;
	end

endmodule : syn_weight_store_checker

bind recall_queue syn_weight_store_checker #(.FIFO_AW(FIFO_AW)) u_checker (
	.clk_i         (clk_i),
	.rst_n_i       (rst_n_i),
	.occupancy_i   (occupancy),
	.wr_ptr_i      (wr_ptr),
	.rd_ptr_i      (rd_ptr),
	.push_i        (push),
	.learn_valid_i (learn_valid_o)
);

`default_nettype wire

// File: verification/syn_weight_store_tb.sv
/*
 * syn_weight_store_tb
 * random recall, learning read/write and clear traffic, checked
 * against a model of the banks, the recall queue and the held code
 */

`timescale 1ns/1ps
`default_nettype none

module syn_weight_store_tb import syn_weight_pkg::*;
();

	localparam int BANK_ADDR_W = 8;
	localparam int FIFO_AW     = 4;
	localparam int ADDR_W      = BANK_SEL_W + BANK_ADDR_W;
	localparam int DEPTH       = 2 ** FIFO_AW;
	localparam int TIMEOUT     = 200;

	typedef logic [ADDR_W-1:0] addr_t;

	// inputs of one cycle, sampled at the following edge
	typedef struct packed {
		logic        rec_en;
		addr_t       rec_addr;
		scale_code_t rec_scale;
		logic        rd_en;
		logic        wr_en;
		logic        wr_cfg;
		addr_t       wr_addr;
		syn_data_t   wr_data;
		logic        start;
	} stim_t;

	logic        clk_i;
	logic        rst_n_i;
	logic        start_i;
	addr_t       recall_addr_i;
	scale_code_t recall_scale_i;
	logic        recall_en_i;
	logic        recall_ready_o;
	logic        learn_rd_en_i;
	logic        learn_valid_o;
	syn_data_t   learn_data_o;
	addr_t       wr_addr_i;
	syn_data_t   wr_data_i;
	logic        wr_en_i;
	logic        wr_config_i;

	// model state, exp_q also holds the entry in flight
	weight_t       mem_model [2 ** ADDR_W];
	recall_entry_t exp_q [$];
	addr_t         written [$];
	scale_code_t   held_code;
	logic          inflight;
	int            ignored;
	int            pop_count;
	int            errors;
	int            timeouts;
	integer        seed;

	syn_weight_store #(.BANK_ADDR_W(BANK_ADDR_W), .FIFO_AW(FIFO_AW)) uut (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.start_i        (start_i),
		.recall_addr_i  (recall_addr_i),
		.recall_scale_i (recall_scale_i),
		.recall_en_i    (recall_en_i),
		.recall_ready_o (recall_ready_o),
		.learn_rd_en_i  (learn_rd_en_i),
		.learn_valid_o  (learn_valid_o),
		.learn_data_o   (learn_data_o),
		.wr_addr_i      (wr_addr_i),
		.wr_data_i      (wr_data_i),
		.wr_en_i        (wr_en_i),
		.wr_config_i    (wr_config_i)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic scale_code_t rand_code();
		logic [31:0] r;
		r = rand_word();
		return r[1:0];
	endfunction

	// shift amounts of codes 0..3
	function automatic int shift_of(input scale_code_t code);
		case (code)
			2'd0:    return 0;
			2'd1:    return 1;
			2'd2:    return 2;
			default: return 4;
		endcase
	endfunction

	function automatic syn_data_t expand_weight(input weight_t w, input scale_code_t code);
		int v;
		v = int'($signed(w)) <<< shift_of(code);
		return v[15:0];
	endfunction

	function automatic weight_t shrink_data(input syn_data_t d, input scale_code_t code);
		syn_data_t t;
		t = d >> shift_of(code);
		return t[11:0];
	endfunction

	function automatic stim_t recall_stim(input scale_code_t code, input logic rd_en);
		stim_t       s;
		logic [31:0] r;
		r           = rand_word();
		s           = '0;
		s.rec_en    = 1'b1;
		s.rec_addr  = written[r % written.size()];
		s.rec_scale = code;
		s.rd_en     = rd_en;
		return s;
	endfunction

	function automatic stim_t write_stim(input logic cfg);
		stim_t       s;
		logic [31:0] r;
		r         = rand_word();
		s         = '0;
		s.wr_en   = 1'b1;
		s.wr_cfg  = cfg;
		s.wr_addr = r[ADDR_W-1:0];
		s.wr_data = r[31:16];
		return s;
	endfunction

	task automatic flag_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, want);
	endtask

	// compare flags, then apply what the next edge does to the model
	task automatic check_cycle(input stim_t s);
		int            occ;
		logic          accept;
		recall_entry_t e;
		occ    = exp_q.size() - int'(inflight);
		accept = s.rec_en && (exp_q.size() < DEPTH);
		assert (learn_valid_o == (occ > 0))
		else
			flag_mismatch("learn_valid_o", 32'(learn_valid_o), 32'(occ > 0));
		assert (recall_ready_o == (exp_q.size() < DEPTH))
		else
			flag_mismatch("recall_ready_o", 32'(recall_ready_o), 32'(exp_q.size() < DEPTH));
		// write uses the code held before a pop at the same edge
		if (s.wr_en)
		begin
			mem_model[s.wr_addr] = s.wr_cfg ? s.wr_data[11:0] : shrink_data(s.wr_data, held_code);
			written.push_back(s.wr_addr);
		end
		if (s.start)
		begin
			exp_q.delete();
			inflight = 1'b0;
		end
		else
		begin
			if (s.rd_en && occ > 0)
			begin
				e = exp_q.pop_front();
				assert (learn_data_o == e.data)
				else
					flag_mismatch("learn_data_o", 32'(learn_data_o), 32'(e.data));
				held_code = e.code;
			end
			// handshakes as the DUT offered them
			if (s.rd_en && learn_valid_o)
				pop_count++;
			if (accept)
			begin
				e.data = expand_weight(mem_model[s.rec_addr], s.rec_scale);
				e.code = s.rec_scale;
				exp_q.push_back(e);
			end
			if (s.rec_en && !recall_ready_o)
				ignored++;
			inflight = accept;
		end
	endtask

	task automatic run_cycle(input stim_t s);
		@(posedge clk_i);
		recall_en_i    <= s.rec_en;
		recall_addr_i  <= s.rec_addr;
		recall_scale_i <= s.rec_scale;
		learn_rd_en_i  <= s.rd_en;
		wr_en_i        <= s.wr_en;
		wr_config_i    <= s.wr_cfg;
		wr_addr_i      <= s.wr_addr;
		wr_data_i      <= s.wr_data;
		start_i        <= s.start;
		@(negedge clk_i);
		check_cycle(s);
	endtask

	task automatic drain_queue();
		stim_t s;
		int    guard;
		s       = '0;
		s.rd_en = 1'b1;
		guard   = 0;
		while ((exp_q.size() > 0 || learn_valid_o) && guard < TIMEOUT)
		begin
			run_cycle(s);
			guard++;
		end
		if (exp_q.size() > 0 || learn_valid_o)
		begin
			timeouts++;
			$display("timeout: recall queue not empty after %0d cycles of pops", TIMEOUT);
		end
		run_cycle('0);
	endtask

	initial
	begin
		stim_t       s;
		logic [31:0] r;
		int          base;
		seed      = 32'hd2ab411c;
		errors    = 0;
		timeouts  = 0;
		ignored   = 0;
		pop_count = 0;
		held_code = '0;
		inflight  = 1'b0;
		rst_n_i        = 1'b0;
		start_i        = 1'b0;
		recall_addr_i  = '0;
		recall_scale_i = '0;
		recall_en_i    = 1'b0;
		learn_rd_en_i  = 1'b0;
		wr_addr_i      = '0;
		wr_data_i      = '0;
		wr_en_i        = 1'b0;
		wr_config_i    = 1'b0;
		repeat (2) @(posedge clk_i);
		rst_n_i <= 1'b1;
		@(negedge clk_i);
		assert (!learn_valid_o)
		else
			flag_mismatch("learn_valid_o after reset", 32'(learn_valid_o), 32'd0);
		assert (recall_ready_o)
		else
			flag_mismatch("recall_ready_o after reset", 32'(recall_ready_o), 32'd1);

		// config writes, then code 0 recalls come back in order
		for (int i = 0; i < 16; i++)
			run_cycle(write_stim(1'b1));
		base = pop_count;
		for (int i = 0; i < 12; i++)
			run_cycle(recall_stim(2'd0, 1'b0));
		drain_queue();
		assert (pop_count - base == 12)
		else
			flag_mismatch("pops after code 0 recalls", 32'(pop_count - base), 32'd12);

		// random codes with pops mixed in
		for (int i = 0; i < 40; i++)
		begin
			r        = rand_word();
			s        = recall_stim(r[1:0], r[2]);
			s.rec_en = r[3] | r[4];
			run_cycle(s);
		end
		drain_queue();

		// learned write scaled back by the code of the last pop
		for (int i = 0; i < 10; i++)
		begin
			run_cycle(recall_stim(rand_code(), 1'b0));
			drain_queue();
			s           = write_stim(1'b0);
			s.rec_en    = 1'b1;
			s.rec_addr  = s.wr_addr;
			s.rec_scale = 2'd0;
			run_cycle(s);
			drain_queue();
		end

		// back-pressure with no pops
		base = ignored;
		for (int i = 0; i < DEPTH + 8; i++)
			run_cycle(recall_stim(rand_code(), 1'b0));
		assert (ignored > base)
		else
		begin
			errors++;
			$display("recall requests were never held back by a full queue");
		end
		base = pop_count;
		drain_queue();
		assert (pop_count - base == DEPTH)
		else
			flag_mismatch("pops after back-pressure", 32'(pop_count - base), 32'(DEPTH));

		// clear right behind a recall, in-flight entry is dropped too
		for (int i = 0; i < 5; i++)
			run_cycle(recall_stim(rand_code(), 1'b0));
		s       = '0;
		s.start = 1'b1;
		run_cycle(s);
		run_cycle('0);
		assert (!learn_valid_o)
		else
			flag_mismatch("learn_valid_o after start", 32'(learn_valid_o), 32'd0);
		base = pop_count;
		for (int i = 0; i < 3; i++)
			run_cycle(recall_stim(rand_code(), 1'b0));
		drain_queue();
		assert (pop_count - base == 3)
		else
			flag_mismatch("pops after start", 32'(pop_count - base), 32'd3);

		// bound queue assertions add to the error count
		errors += uut.u_recall_queue.u_checker.fail_count;

		$display("errors: %0d, timeouts: %0d, pops checked: %0d", errors, timeouts, pop_count);
		if (errors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule : syn_weight_store_tb

`default_nettype wire

// File: syn_weight_store.f
source/syn_weight_pkg.sv
source/weight_recall_port.sv
source/weight_bank_array.sv
source/learn_writeback.sv
source/recall_queue.sv
source/syn_weight_store.sv
verification/syn_weight_store_checker.sv
verification/syn_weight_store_tb.sv

// File: Makefile
# Verilator build and run of the synaptic weight store testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := syn_weight_store_tb
FILELIST := syn_weight_store.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
